// File: Makefile
TOP = tb_sms_mem_ctrl

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@grep -qx "sim passed" sim.log && echo "PASS" || (echo "FAIL, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: all.f
rtl/sms_mem_pkg.sv
rtl/msx_detect.sv
rtl/mapper_regs.sv
rtl/rom_addr_map.sv
rtl/mem_decode.sv
rtl/sms_mem_ctrl.sv
bench/tb_sms_mem_ctrl.sv

// File: bench/sms_mem_golden.txt
# op addr data expect, all hex; for I the data 1 selects the msx image
# W ignores expect, R checks rom_a, D checks rdata
I 0000 00 000000
R 4123 00 004123
W fffd 05 000000
W fffe 06 000000
W ffff 07 000000
R 0123 00 000123
R 0523 00 014523
R 7fff 00 01bfff
R bfff 00 01ffff
W c010 a5 000000
W fffc 10 000000
W c010 3c 000000
D c010 00 00003c
W fffc 08 000000
D c010 00 0000a5
W 8020 66 000000
W fffc 0c 000000
W 8020 99 000000
W fffc 08 000000
D 8020 00 000066
I 0000 00 000000
W 8000 09 000000
R 8000 00 024000
W 8000 0b 000000
R 8004 00 024004
W a000 0c 000000
R a123 00 032123
W 0000 03 000000
R 0010 00 00c010
W 4000 85 000000
R 4000 00 014000
I 0000 01 000000
D 0000 00 000041
D 0001 00 000042
W 0000 10 000000
W 0002 20 000000
R 4010 00 040010
R 8010 00 020010

// File: bench/tb_sms_mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sms_mem_ctrl;
   import sms_mem_pkg::*;

   localparam int RESET_CYCLES = 16;

   logic                    clk_sys;
   logic                    RESET_n;
   z80_bus_t                bus;
   logic                    mapper_lock;
   logic [DATA_W-1:0]       rdata;
   logic                    rom_rd;
   logic [ROM_ADDR_W-1:0]   rom_a;
   logic [DATA_W-1:0]       rom_q;
   logic [RAM_ADDR_W-1:0]   ram_a;
   logic [DATA_W-1:0]       ram_d;
   logic                    ram_we;
   logic [DATA_W-1:0]       ram_q;
   logic [NVRAM_ADDR_W-1:0] nvram_a;
   logic [DATA_W-1:0]       nvram_d;
   logic                    nvram_we;
   logic [DATA_W-1:0]       nvram_q;

   logic [DATA_W-1:0] ram_mem   [0:(1 << RAM_ADDR_W)-1];
   logic [DATA_W-1:0] nvram_mem [0:(1 << NVRAM_ADDR_W)-1];
   logic              msx_image;   // rom starts with the msx signature

   byte         op_q   [$];
   logic [31:0] addr_q [$];
   logic [31:0] data_q [$];
   logic [31:0] exp_q  [$];
   int          cycles      = 0;
   int          cycle_limit = 100000;
   bit          loaded;

   sms_mem_ctrl u_sms_mem_ctrl (
      .clk_sys     (clk_sys),
      .RESET_n     (RESET_n),
      .bus         (bus),
      .mapper_lock (mapper_lock),
      .rdata       (rdata),
      .rom_rd      (rom_rd),
      .rom_a       (rom_a),
      .rom_q       (rom_q),
      .ram_a       (ram_a),
      .ram_d       (ram_d),
      .ram_we      (ram_we),
      .ram_q       (ram_q),
      .nvram_a     (nvram_a),
      .nvram_d     (nvram_d),
      .nvram_we    (nvram_we),
      .nvram_q     (nvram_q)
   );

   initial begin
      clk_sys = 1'b0;
      forever begin
         #10 clk_sys = ~clk_sys;
      end
   end

   // every bank reads back a different byte
   always_comb begin
      if (msx_image && rom_a == 22'd0) begin
         rom_q = 8'h41;
      end else if (msx_image && rom_a == 22'd1) begin
         rom_q = 8'h42;
      end else begin
         rom_q = rom_a[7:0] ^ rom_a[21:14] ^ {2'b00, rom_a[13:8]};
      end
   end

   assign ram_q   = ram_mem[ram_a];
   assign nvram_q = nvram_mem[nvram_a];

   always @(posedge clk_sys) begin
      if (ram_we) begin
         ram_mem[ram_a] <= ram_d;
      end
      if (nvram_we) begin
         nvram_mem[nvram_a] <= nvram_d;
      end
   end

   always @(posedge clk_sys) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("sim failed");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic apply_reset(input logic img);
      @(posedge clk_sys);
      RESET_n   <= 1'b0;
      msx_image <= img;
      repeat (RESET_CYCLES) @(posedge clk_sys);
      RESET_n <= 1'b1;
   endtask

   // strobes low for two clocks, then one idle clock
   task automatic bus_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data,
                            output logic [ROM_ADDR_W-1:0] rom_a_seen,
                            output logic [DATA_W-1:0] rdata_seen,
                            output logic rom_rd_seen);
      z80_bus_t cyc;

      cyc.mreq_n = 1'b0;
      cyc.rd_n   = wr;
      cyc.wr_n   = ~wr;
      cyc.addr   = addr;
      cyc.wdata  = data;
      @(posedge clk_sys);
      bus <= cyc;
      @(posedge clk_sys);
      @(negedge clk_sys);   // outputs settled by mid cycle
      rom_a_seen  = rom_a;
      rdata_seen  = rdata;
      rom_rd_seen = rom_rd;
      @(posedge clk_sys);
      cyc.mreq_n = 1'b1;
      cyc.rd_n   = 1'b1;
      cyc.wr_n   = 1'b1;
      bus <= cyc;
   endtask

   task automatic load_vectors(output bit ok);
      int          fd;
      int          n_init;
      string       tok;
      string       rest;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;

      n_init = 0;
      fd = $fopen("bench/sms_mem_golden.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
               void'($fgets(rest, fd));   // column notes
            end else begin
               void'($fscanf(fd, "%h %h %h", a, d, e));
               op_q.push_back(tok[0]);
               addr_q.push_back(a);
               data_q.push_back(d);
               exp_q.push_back(e);
               if (tok[0] == "I") begin
                  n_init++;
               end
            end
         end
         $fclose(fd);
         cycle_limit = 3 * op_q.size() + (RESET_CYCLES + 1) * (n_init + 1) + 50;
      end
   endtask

   task automatic run_vectors();
      logic [ROM_ADDR_W-1:0] seen_a;
      logic [DATA_W-1:0]     seen_d;
      logic                  seen_rd;
      logic [31:0]           a;

      foreach (op_q[i]) begin
         a = addr_q[i];
         case (op_q[i])
            "I": apply_reset(data_q[i][0]);
            "W": begin
               bus_cycle(1'b1, a[15:0], data_q[i][7:0], seen_a, seen_d, seen_rd);
               check({31'b0, seen_rd}, 32'd0, $sformatf("rom_rd on write of %h", a[15:0]));
            end
            "R": begin
               bus_cycle(1'b0, a[15:0], 8'h00, seen_a, seen_d, seen_rd);
               check({10'b0, seen_a}, exp_q[i], $sformatf("rom_a on read of %h", a[15:0]));
               check({31'b0, seen_rd}, 32'd1, $sformatf("rom_rd on read of %h", a[15:0]));
            end
            "D": begin
               bus_cycle(1'b0, a[15:0], 8'h00, seen_a, seen_d, seen_rd);
               check({24'b0, seen_d}, exp_q[i], $sformatf("rdata on read of %h", a[15:0]));
            end
            default: begin
               $display("unknown opcode %s in the stimulus file", op_q[i]);
               $display("sim failed");
               $fatal(1, "bad stimulus");
            end
         endcase
      end
   endtask

   initial begin
      RESET_n     <= 1'b0;
      mapper_lock <= 1'b0;
      msx_image   <= 1'b0;
      bus         <= {1'b1, 1'b1, 1'b1, 16'h0000, 8'h00};
      load_vectors(loaded);
      if (!loaded) begin
         $display("could not open the stimulus file bench/sms_mem_golden.txt");
         $display("sim failed");
         $fatal(1, "no stimulus");
      end else begin
         apply_reset(1'b0);
         run_vectors();
         $display("sim passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: rtl/mapper_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mapper_regs (
   input  logic                   clk_sys,
   input  logic                   RESET_n,
   input  sms_mem_pkg::z80_bus_t  bus,
   input  logic                   msx_mode,
   input  logic                   mapper_lock,
   output sms_mem_pkg::bank_set_t banks,
   output sms_mem_pkg::cart_ram_t cram,
   output logic                   codies
);
   import sms_mem_pkg::*;

   logic [ADDR_W-1:0] last_rd_addr;
   logic              cm_lock;       // codemasters writes seen at 4000/8000
   logic              codies_lock;   // only one chance to pick the codies mapper
   logic              mem_wr;
   logic              mem_rd;
   logic              cm_wr;
   logic [DATA_W-1:0] d;

   assign mem_wr = ~bus.mreq_n & ~bus.wr_n;
   assign mem_rd = ~bus.mreq_n & ~bus.rd_n;
   assign cm_wr  = mem_wr & ~cram.en & ~mapper_lock;
   assign d      = bus.wdata;

   // block-copy loops read then write the same address, remember the read
   always_ff @(posedge clk_sys) begin
      if (!RESET_n) begin
         last_rd_addr <= '0;
      end else if (mem_rd) begin
         last_rd_addr <= bus.addr;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (!RESET_n) begin
         banks.bank0 <= BANK_RESET0;
         banks.bank1 <= BANK_RESET1;
         banks.bank2 <= BANK_RESET2;
         banks.bank3 <= BANK_RESET3;
         cram        <= '0;
         cm_lock     <= 1'b0;
         codies      <= 1'b0;
         codies_lock <= 1'b0;
      end else if (msx_mode) begin
         if (mem_wr && bus.addr[15:2] == 14'h0000) begin
            case (bus.addr[1:0])
               2'b00: banks.bank2 <= d;
               2'b01: banks.bank3 <= d;
               2'b10: banks.bank0 <= d;
               2'b11: banks.bank1 <= d;
            endcase
         end
      end else begin
         // sega mapper, fffc-ffff
         if (mem_wr && bus.addr[15:2] == 14'h3fff) begin
            codies <= 1'b0;
            case (bus.addr[1:0])
               2'b00: begin
                  cram.ext  <= d[4];
                  cram.en   <= d[3];
                  cram.page <= d[2];
               end
               2'b01: banks.bank0 <= d;
               2'b10: banks.bank1 <= d;
               2'b11: banks.bank2 <= d;
            endcase
         end

         if (cm_wr) begin
            case (bus.addr)
               16'h0000: begin
                  // ignored until a codemasters write has been seen
                  if (cm_lock) begin
                     banks.bank0 <= d;
                     if (d != '0 && !codies_lock) begin
                        if (banks.bank1 == BANK_RESET1) begin
                           codies <= 1'b1;
                        end
                        codies_lock <= 1'b1;
                     end
                  end
               end
               16'h4000: begin
                  if (last_rd_addr != 16'h4000) begin
                     banks.bank1 <= {1'b0, d[6:0]};
                     cram.cme    <= d[7];
                     cm_lock     <= 1'b1;
                  end
               end
               16'h8000: begin
                  if (last_rd_addr != 16'h8000) begin
                     banks.bank2 <= d;
                     cm_lock     <= 1'b1;
                  end
               end
               16'ha000: begin
                  // korean style bank write
                  if (last_rd_addr != 16'ha000 && !codies) begin
                     banks.bank2 <= d;
                  end
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/mem_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mem_decode (
   input  sms_mem_pkg::z80_bus_t                bus,
   input  sms_mem_pkg::cart_ram_t               cram,
   input  logic [sms_mem_pkg::DATA_W-1:0]       rom_q,
   input  logic [sms_mem_pkg::DATA_W-1:0]       ram_q,
   input  logic [sms_mem_pkg::DATA_W-1:0]       nvram_q,
   output logic [sms_mem_pkg::RAM_ADDR_W-1:0]   ram_a,
   output logic [sms_mem_pkg::DATA_W-1:0]       ram_d,
   output logic                                 ram_we,
   output logic [sms_mem_pkg::NVRAM_ADDR_W-1:0] nvram_a,
   output logic [sms_mem_pkg::DATA_W-1:0]       nvram_d,
   output logic                                 nvram_we,
   output logic                                 rom_rd,
   output logic [sms_mem_pkg::DATA_W-1:0]       rdata
);
   import sms_mem_pkg::*;

   mem_sel_e sel;
   logic     mem_cyc;

   assign mem_cyc = ~bus.mreq_n;

   always_comb begin
      if (bus.addr[15:14] == 2'b11) begin
         sel = cram.ext ? SEL_NVRAM : SEL_RAM;
      end else if (bus.addr[15:13] == 3'b101 && cram.cme) begin
         sel = SEL_NVRAM;
      end else if (bus.addr[15:14] == 2'b10 && cram.en) begin
         sel = SEL_NVRAM;
      end else begin
         sel = SEL_ROM;
      end
   end

   assign ram_a   = bus.addr[RAM_ADDR_W-1:0];   // mirrored every 8 KB
   assign ram_d   = bus.wdata;
   assign nvram_a = {cram.page & ~bus.addr[14], bus.addr[13:0]};
   assign nvram_d = bus.wdata;

   assign ram_we   = mem_cyc & ~bus.wr_n & (sel == SEL_RAM);
   assign nvram_we = mem_cyc & ~bus.wr_n & (sel == SEL_NVRAM);
   assign rom_rd   = mem_cyc & ~bus.rd_n & (sel == SEL_ROM);

   always_comb begin
      case (sel)
         SEL_RAM:   rdata = ram_q;
         SEL_NVRAM: rdata = nvram_q;
         default:   rdata = rom_q;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/msx_detect.sv
`timescale 1ns/100ps
`default_nettype none

module msx_detect (
   input  logic                           clk_sys,
   input  logic                           RESET_n,
   input  sms_mem_pkg::z80_bus_t          bus,
   input  logic [sms_mem_pkg::DATA_W-1:0] rdata,
   output logic                           msx_mode
);
   import sms_mem_pkg::*;

   msx_det_e state;
   logic     sig0_ok;   // 41 seen at 0000
   logic     sig1_ok;   // 42 seen at 0001

   always_ff @(posedge clk_sys) begin
      if (!RESET_n) begin
         state    <= DET_WATCH;
         sig0_ok  <= 1'b0;
         sig1_ok  <= 1'b0;
         msx_mode <= 1'b0;
      end else begin
         case (state)
            DET_WATCH, DET_ARMED: begin
               if (!bus.mreq_n) begin
                  // address is stable during the cycle, data follows the mux
                  if (bus.addr == 16'h0000) begin
                     sig0_ok <= (rdata == MSX_SIG0);
                  end else if (bus.addr == 16'h0001) begin
                     sig1_ok <= (rdata == MSX_SIG1);
                     state   <= DET_ARMED;
                  end
               end else if (state == DET_ARMED) begin
                  // first idle edge after 0001, decide once
                  msx_mode <= sig0_ok & sig1_ok;
                  state    <= (sig0_ok && sig1_ok) ? DET_FOUND : DET_DONE;
               end
            end
            DET_FOUND: begin
               state <= DET_DONE;   // msx_mode stays latched
            end
            default: begin
               state <= DET_DONE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/rom_addr_map.sv
`timescale 1ns/100ps
`default_nettype none

module rom_addr_map (
   input  logic [sms_mem_pkg::ADDR_W-1:0]     addr,
   input  sms_mem_pkg::bank_set_t             banks,
   input  sms_mem_pkg::mapper_mode_e          mode,
   output logic [sms_mem_pkg::ROM_ADDR_W-1:0] rom_a
);
   import sms_mem_pkg::*;

   always_comb begin
      rom_a[12:0] = addr[12:0];   // offset inside an 8 KB page
      if (mode == MAP_MSX) begin
         // 8 KB windows, 4000-bfff banked
         case (addr[15:13])
            3'd2:    rom_a[21:13] = {1'b0, banks.bank0};
            3'd3:    rom_a[21:13] = {1'b0, banks.bank1};
            3'd4:    rom_a[21:13] = {1'b0, banks.bank2};
            3'd5:    rom_a[21:13] = {1'b0, banks.bank3};
            default: rom_a[21:13] = {6'b000000, addr[15:13]};
         endcase
      end else begin
         // 16 KB windows
         rom_a[13] = addr[13];
         case (addr[15:14])
            2'b00: begin
               // first kilobyte fixed, except on the codies mapper
               if (addr[13:10] == 4'b0000 && mode != MAP_CODIES) begin
                  rom_a[21:14] = '0;
               end else begin
                  rom_a[21:14] = banks.bank0;
               end
            end
            2'b01:   rom_a[21:14] = banks.bank1;
            default: rom_a[21:14] = banks.bank2;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/sms_mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sms_mem_ctrl (
   input  logic                                 clk_sys,
   input  logic                                 RESET_n,
   input  sms_mem_pkg::z80_bus_t                bus,
   input  logic                                 mapper_lock,   // no codemasters/korean writes
   output logic [sms_mem_pkg::DATA_W-1:0]       rdata,
   output logic                                 rom_rd,
   output logic [sms_mem_pkg::ROM_ADDR_W-1:0]   rom_a,
   input  logic [sms_mem_pkg::DATA_W-1:0]       rom_q,
   output logic [sms_mem_pkg::RAM_ADDR_W-1:0]   ram_a,
   output logic [sms_mem_pkg::DATA_W-1:0]       ram_d,
   output logic                                 ram_we,
   input  logic [sms_mem_pkg::DATA_W-1:0]       ram_q,
   output logic [sms_mem_pkg::NVRAM_ADDR_W-1:0] nvram_a,
   output logic [sms_mem_pkg::DATA_W-1:0]       nvram_d,
   output logic                                 nvram_we,
   input  logic [sms_mem_pkg::DATA_W-1:0]       nvram_q
);
   import sms_mem_pkg::*;

   bank_set_t    banks;
   cart_ram_t    cram;
   logic         codies;
   logic         msx_mode;
   mapper_mode_e mode;

   // msx wins, it is latched once and never cleared until reset
   assign mode = msx_mode ? MAP_MSX : (codies ? MAP_CODIES : MAP_SEGA);

   msx_detect u_msx_detect (
      .clk_sys  (clk_sys),
      .RESET_n  (RESET_n),
      .bus      (bus),
      .rdata    (rdata),
      .msx_mode (msx_mode)
   );

   mapper_regs u_mapper_regs (
      .clk_sys     (clk_sys),
      .RESET_n     (RESET_n),
      .bus         (bus),
      .msx_mode    (msx_mode),
      .mapper_lock (mapper_lock),
      .banks       (banks),
      .cram        (cram),
      .codies      (codies)
   );

   rom_addr_map u_rom_addr_map (
      .addr  (bus.addr),
      .banks (banks),
      .mode  (mode),
      .rom_a (rom_a)
   );

   mem_decode u_mem_decode (
      .bus      (bus),
      .cram     (cram),
      .rom_q    (rom_q),
      .ram_q    (ram_q),
      .nvram_q  (nvram_q),
      .ram_a    (ram_a),
      .ram_d    (ram_d),
      .ram_we   (ram_we),
      .nvram_a  (nvram_a),
      .nvram_d  (nvram_d),
      .nvram_we (nvram_we),
      .rom_rd   (rom_rd),
      .rdata    (rdata)
   );

endmodule

`default_nettype wire

// File: rtl/sms_mem_pkg.sv
`default_nettype none

package sms_mem_pkg;

   // bus and memory widths
   localparam int ADDR_W       = 16;
   localparam int DATA_W       = 8;
   localparam int ROM_ADDR_W   = 22;
   localparam int RAM_ADDR_W   = 13;   // 8 KB work ram
   localparam int NVRAM_ADDR_W = 15;   // two 16 KB pages

   // power-up bank layout, first 64 KB of the cartridge
   localparam logic [DATA_W-1:0] BANK_RESET0 = 8'h00;
   localparam logic [DATA_W-1:0] BANK_RESET1 = 8'h01;
   localparam logic [DATA_W-1:0] BANK_RESET2 = 8'h02;
   localparam logic [DATA_W-1:0] BANK_RESET3 = 8'h03;

   // msx cartridges start with "AB"
   localparam logic [DATA_W-1:0] MSX_SIG0 = 8'h41;
   localparam logic [DATA_W-1:0] MSX_SIG1 = 8'h42;

   typedef struct packed {
      logic              mreq_n;
      logic              rd_n;
      logic              wr_n;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } z80_bus_t;

   typedef struct packed {
      logic [DATA_W-1:0] bank0;
      logic [DATA_W-1:0] bank1;
      logic [DATA_W-1:0] bank2;
      logic [DATA_W-1:0] bank3;
   } bank_set_t;

   typedef struct packed {
      logic en;     // backup ram at 8000-bfff
      logic ext;    // backup ram at c000-ffff
      logic page;
      logic cme;    // codemasters extension at a000-bfff
   } cart_ram_t;

   typedef enum logic [1:0] {
      MAP_SEGA,
      MAP_CODIES,
      MAP_MSX
   } mapper_mode_e;

   typedef enum logic [1:0] {
      DET_WATCH,
      DET_ARMED,
      DET_FOUND,
      DET_DONE
   } msx_det_e;

   typedef enum logic [1:0] {
      SEL_ROM,
      SEL_RAM,
      SEL_NVRAM
   } mem_sel_e;

endpackage

`default_nettype wire
